// ==== src.f ====
+incdir+include
hdl/dispatch_pkg.sv
hdl/rob_view_if.sv
hdl/dispatch_vrf_port_alloc.sv
hdl/dispatch_operand_resolve.sv
hdl/dispatch_ctrl.sv
hdl/rvv_dispatch.sv
testbench/tb_dispatch.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the dispatch testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --assert --timing --timescale 1ns/1ps \
        -f src.f --top-module tb_dispatch -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_dispatch > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -qx "PASS: all tests" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== include/dispatch_tb_model.svh ====
// Reference model functions for the dispatch testbench, included inside the testbench module
`ifndef DISPATCH_TB_MODEL_SVH
`define DISPATCH_TB_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
endfunction

// Data the VRF model returns for a register
function automatic vdata_t vrf_pattern(input vreg_idx_t idx);
    return {4{3'b101, idx}} ^ 32'h3C96_5AF0;
endfunction

function automatic int src_count(input uop_t u);
    return int'(u.vs1_valid) + int'(u.vs2_valid) + int'(u.vs3_valid);
endfunction

// VRF read index per port, valid operands in queue order and idle ports at v0
function automatic void alloc_ports(
    input  logic      [1:0]               valid,
    input  uop_t      [1:0]               uops,
    output vreg_idx_t [NUM_VRF_PORT-1:0]  idx
);
    int next;
    idx  = '0;
    next = 0;
    for (int s = 0; s < 2; s++) begin
        if (valid[s] && uops[s].vs1_valid && next < NUM_VRF_PORT) begin
            idx[next] = uops[s].vs1_index;
            next++;
        end
        if (valid[s] && uops[s].vs2_valid && next < NUM_VRF_PORT) begin
            idx[next] = uops[s].vs2_index;
            next++;
        end
        if (valid[s] && uops[s].vs3_valid && next < NUM_VRF_PORT) begin
            idx[next] = uops[s].vd_index;
            next++;
        end
    end
endfunction

// Youngest valid ROB writer of idx decides stall and data
function automatic void exp_source(
    input  logic                       valid,
    input  vreg_idx_t                  idx,
    input  rob_idx_t                   tail,
    input  logic      [ROB_DEPTH-1:0]  entry_valid,
    input  vreg_idx_t [ROB_DEPTH-1:0]  w_index,
    input  logic      [ROB_DEPTH-1:0]  w_ready,
    input  vdata_t    [ROB_DEPTH-1:0]  w_data,
    output logic                       stall,
    output vdata_t                     data
);
    rob_idx_t e;
    stall = 1'b0;
    data  = valid ? vrf_pattern(idx) : '0;
    for (int d = 0; d < ROB_DEPTH; d++) begin
        e = tail - rob_idx_t'(d + 1);
        if (valid && entry_valid[e] && w_index[e] == idx) begin
            stall = !w_ready[e];
            data  = w_data[e];
            break;
        end
    end
endfunction

// Expected can_issue per slot, bit 0 for slot 0
function automatic logic [1:0] exp_can_issue(
    input logic [1:0]  valid,
    input uop_t [1:0]  uops,
    input logic [1:0]  stall,
    input logic [1:0]  alu_rdy,
    input logic [1:0]  mul_rdy,
    input logic [1:0]  rob_rdy
);
    logic [1:0] ok;
    logic       pair;
    logic       ports;
    for (int s = 0; s < 2; s++) begin
        ok[s] = valid[s] && !stall[s] && rob_rdy[s]
             && (uops[s].exe_unit == EXE_MUL ? mul_rdy[s] : alu_rdy[s]);
    end
    pair = uops[0].vd_valid
        && ((uops[1].vs1_valid && uops[1].vs1_index == uops[0].vd_index)
         || (uops[1].vs2_valid && uops[1].vs2_index == uops[0].vd_index)
         || (uops[1].vs3_valid && uops[1].vd_index == uops[0].vd_index));
    ports = (src_count(uops[0]) + src_count(uops[1])) > NUM_VRF_PORT;
    return {ok[0] && ok[1] && !pair && !ports, ok[0]};
endfunction

`endif

// ==== testbench/tb_dispatch.sv ====
// Randomized self-checking testbench for the two-wide dispatch stage, run through src.f
module tb_dispatch
    import dispatch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic                          clk;
    logic                          rst;
    logic      [NUM_DP_UOP-1:0]    uop_valid;
    uop_t      [NUM_DP_UOP-1:0]    uop;
    logic      [NUM_DP_UOP-1:0]    uop_ready;
    logic      [NUM_DP_UOP-1:0]    rs_valid_alu;
    logic      [NUM_DP_UOP-1:0]    rs_ready_alu;
    logic      [NUM_DP_UOP-1:0]    rs_valid_mul;
    logic      [NUM_DP_UOP-1:0]    rs_ready_mul;
    rs_uop_t   [NUM_DP_UOP-1:0]    rs_uop;
    logic      [NUM_DP_UOP-1:0]    rob_valid;
    logic      [NUM_DP_UOP-1:0]    rob_ready;
    rob_push_t [NUM_DP_UOP-1:0]    rob_push;
    rob_idx_t                      rob_tail;
    logic      [ROB_DEPTH-1:0]     rob_entry_valid;
    vreg_idx_t [ROB_DEPTH-1:0]     rob_w_index;
    logic      [ROB_DEPTH-1:0]     rob_w_ready;
    vdata_t    [ROB_DEPTH-1:0]     rob_w_data;
    vreg_idx_t [NUM_VRF_PORT-1:0]  vrf_rd_index;
    vdata_t    [NUM_VRF_PORT-1:0]  vrf_rd_data;

    logic   [15:0]                           lfsr_state;
    int                                      error_count = 0;
    logic   [NUM_DP_UOP-1:0][NUM_SRC-1:0]    src_stall;
    vdata_t [NUM_DP_UOP-1:0][NUM_SRC-1:0]    exp_data;
    logic   [NUM_DP_UOP-1:0]                 exp_stall;
    logic   [NUM_DP_UOP-1:0]                 exp_issue;
    logic   [NUM_DP_UOP-1:0]                 to_mul;
    logic   [NUM_DP_UOP-1:0]                 tgt_ready;
    logic                                    pair_hazard;
    logic                                    port_overflow;
    vreg_idx_t [NUM_VRF_PORT-1:0]            exp_rd_index;
    // funct6, rs1_data and the three operand valid bits
    logic   [NUM_DP_UOP-1:0][16:0]           exp_fields;
    logic   [NUM_DP_UOP-1:0][16:0]           got_fields;
    // Bits: vrf, bypass, stall, pair, struct, backpressure, idle, dual issue
    logic   [7:0]                            covered = '0;

    `include "dispatch_tb_model.svh"

    rvv_dispatch rvv_dispatch_i (.*);

    always begin
        clk = 1'b0;
        #4;
        clk = 1'b1;
        #4;
    end

    // VRF model, same-cycle read
    always_comb begin
        for (int p = 0; p < NUM_VRF_PORT; p++) begin
            vrf_rd_data[p] = vrf_pattern(vrf_rd_index[p]);
        end
    end

    function automatic logic reads_reg(input uop_t u, input vreg_idx_t r);
        return (u.vs1_valid && u.vs1_index == r) || (u.vs2_valid && u.vs2_index == r)
            || (u.vs3_valid && u.vd_index == r);
    endfunction

    function automatic int rob_matches(input vreg_idx_t idx);
        int n;
        n = 0;
        for (int e = 0; e < ROB_DEPTH; e++) begin
            if (rob_entry_valid[e] && rob_w_index[e] == idx) begin
                n++;
            end
        end
        return n;
    endfunction

    always_comb begin
        for (int s = 0; s < NUM_DP_UOP; s++) begin
            exp_source(uop[s].vs1_valid, uop[s].vs1_index, rob_tail, rob_entry_valid,
                       rob_w_index, rob_w_ready, rob_w_data, src_stall[s][0], exp_data[s][0]);
            exp_source(uop[s].vs2_valid, uop[s].vs2_index, rob_tail, rob_entry_valid,
                       rob_w_index, rob_w_ready, rob_w_data, src_stall[s][1], exp_data[s][1]);
            exp_source(uop[s].vs3_valid, uop[s].vd_index, rob_tail, rob_entry_valid,
                       rob_w_index, rob_w_ready, rob_w_data, src_stall[s][2], exp_data[s][2]);
            exp_stall[s] = |src_stall[s];
            to_mul[s]    = (uop[s].exe_unit == EXE_MUL);
            tgt_ready[s] = to_mul[s] ? rs_ready_mul[s] : rs_ready_alu[s];
            exp_fields[s] = {uop[s].funct6, uop[s].rs1_data, uop[s].vs1_valid,
                             uop[s].vs2_valid, uop[s].vs3_valid};
            got_fields[s] = {rs_uop[s].funct6, rs_uop[s].rs1_data, rs_uop[s].vs1_data_valid,
                             rs_uop[s].vs2_data_valid, rs_uop[s].vs3_data_valid};
        end
        exp_issue = exp_can_issue(uop_valid, uop, exp_stall, rs_ready_alu, rs_ready_mul,
                                  rob_ready);
        pair_hazard   = uop[0].vd_valid && reads_reg(uop[1], uop[0].vd_index);
        port_overflow = (src_count(uop[0]) + src_count(uop[1])) > NUM_VRF_PORT;
        alloc_ports(uop_valid, uop, exp_rd_index);
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "dispatch testbench stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int slot,
                                   input logic [31:0] expected, input logic [31:0] actual);
        error_count++;
        $display("FAIL %s slot %0d: expected %h, actual %h at %0t",
                 name, slot, expected, actual, $time);
        abort_run();
    endtask

    for (genvar s = 0; s < NUM_DP_UOP; s++) begin : g_check
        a_issue: assert property (@(posedge clk) uop_ready[s] == exp_issue[s])
            else report_mismatch("issue_decision", s, 32'(exp_issue[s]), 32'(uop_ready[s]));
        a_rob_valid: assert property (@(posedge clk) rob_valid[s] == exp_issue[s])
            else report_mismatch("rob_valid", s, 32'(exp_issue[s]), 32'(rob_valid[s]));
        a_steer_alu: assert property (@(posedge clk)
            rs_valid_alu[s] == (exp_issue[s] && !to_mul[s]))
            else report_mismatch("steer_alu", s, 32'(exp_issue[s] && !to_mul[s]),
                                 32'(rs_valid_alu[s]));
        a_steer_mul: assert property (@(posedge clk)
            rs_valid_mul[s] == (exp_issue[s] && to_mul[s]))
            else report_mismatch("steer_mul", s, 32'(exp_issue[s] && to_mul[s]),
                                 32'(rs_valid_mul[s]));
        a_vs1: assert property (@(posedge clk) exp_issue[s] |-> rs_uop[s].vs1_data == exp_data[s][0])
            else report_mismatch("operand_vs1", s, exp_data[s][0], rs_uop[s].vs1_data);
        a_vs2: assert property (@(posedge clk) exp_issue[s] |-> rs_uop[s].vs2_data == exp_data[s][1])
            else report_mismatch("operand_vs2", s, exp_data[s][1], rs_uop[s].vs2_data);
        a_vs3: assert property (@(posedge clk) exp_issue[s] |-> rs_uop[s].vs3_data == exp_data[s][2])
            else report_mismatch("operand_vs3", s, exp_data[s][2], rs_uop[s].vs3_data);
        a_rob_idx: assert property (@(posedge clk)
            exp_issue[s] |-> rs_uop[s].rob_idx == rob_tail + rob_idx_t'(s))
            else report_mismatch("rob_idx", s, 32'(rob_idx_t'(rob_tail + rob_idx_t'(s))),
                                 32'(rs_uop[s].rob_idx));
        a_payload: assert property (@(posedge clk)
            exp_issue[s] |-> got_fields[s] == exp_fields[s])
            else report_mismatch("payload_fields", s, 32'(exp_fields[s]), 32'(got_fields[s]));
        a_rob_push: assert property (@(posedge clk)
            exp_issue[s] |-> rob_push[s] == {uop[s].vd_index, uop[s].vd_valid})
            else report_mismatch("rob_push", s, 32'({uop[s].vd_index, uop[s].vd_valid}),
                                 32'(rob_push[s]));
        // A slot blocked by its own stall or ready also blocks every later slot
        a_hold: assert property (@(posedge clk)
            (exp_stall[s] || !tgt_ready[s] || !rob_ready[s]) |-> (uop_ready >> s) == '0)
            else report_mismatch("stall_or_backpressure", s, 32'(0), 32'(uop_ready));
        a_idle: assert property (@(posedge clk) (uop_valid == '0) |->
            {uop_ready[s], rob_valid[s], rs_valid_alu[s], rs_valid_mul[s]} == 4'b0000)
            else report_mismatch("idle_outputs", s, 32'(0),
                32'({uop_ready[s], rob_valid[s], rs_valid_alu[s], rs_valid_mul[s]}));
    end

    a_pair_block: assert property (@(posedge clk)
        (pair_hazard || port_overflow) |-> !uop_ready[1])
        else report_mismatch("pair_or_port_hazard", 1, 32'(0), 32'(uop_ready[1]));

    // Read ports in operand order, idle ports on v0
    a_vrf_index: assert property (@(posedge clk) vrf_rd_index == exp_rd_index)
        else report_mismatch("vrf_rd_index", 0, 32'(exp_rd_index), 32'(vrf_rd_index));

    // Records which checked behaviors the stimulus has reached
    always @(posedge clk) begin
        if (!rst) begin
            for (int s = 0; s < NUM_DP_UOP; s++) begin
                if (exp_issue[s] && uop[s].vs1_valid && rob_matches(uop[s].vs1_index) == 0) begin
                    covered[0] <= 1'b1;
                end
                if (exp_issue[s] && uop[s].vs1_valid && rob_matches(uop[s].vs1_index) >= 2) begin
                    covered[1] <= 1'b1;
                end
            end
            covered[2] <= covered[2] | (uop_valid[0] & exp_stall[0] & uop_valid[1]);
            covered[3] <= covered[3] | (exp_issue[0] & uop_valid[1] & pair_hazard);
            covered[4] <= covered[4] | (exp_issue[0] & uop_valid[1] & port_overflow);
            covered[5] <= covered[5] | (uop_valid[0] & ~exp_stall[0]
                                        & (~tgt_ready[0] | ~rob_ready[0]));
            covered[6] <= covered[6] | (uop_valid == '0);
            covered[7] <= covered[7] | (exp_issue == 2'b11);
        end
    end

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // High three times out of four
    task automatic take_mostly_high(output logic bit_out);
        logic [31:0] r;
        take_bits(2, r);
        bit_out = (r[1:0] != 2'b00);
    endtask

    task automatic drive_idle();
        uop_valid       = '0;
        uop             = '0;
        rs_ready_alu    = '1;
        rs_ready_mul    = '1;
        rob_ready       = '1;
        rob_tail        = '0;
        rob_entry_valid = '0;
        rob_w_index     = '0;
        rob_w_ready     = '1;
        rob_w_data      = '0;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic        b;
        logic        idle;
        uop_t        u;
        take_bits(4, r);
        idle = (r[3:0] == 4'd0);
        for (int s = 0; s < NUM_DP_UOP; s++) begin
            take_mostly_high(b);
            uop_valid[s] = b && !idle;
            // Register indices stay below 8 so ROB and pair matches are frequent
            take_bits(3, r);
            u.vs1_index = {2'b00, r[2:0]};
            take_bits(1, r);
            u.vs1_valid = r[0];
            take_bits(3, r);
            u.vs2_index = {2'b00, r[2:0]};
            take_bits(1, r);
            u.vs2_valid = r[0];
            take_bits(3, r);
            u.vd_index  = {2'b00, r[2:0]};
            take_bits(1, r);
            u.vs3_valid = r[0];
            take_bits(1, r);
            u.vd_valid  = r[0];
            take_bits(1, r);
            u.exe_unit  = exe_unit_e'(r[0]);
            take_bits(6, r);
            u.funct6    = r[5:0];
            take_bits(8, r);
            u.rs1_data  = r[7:0];
            uop[s] = u;
            take_mostly_high(b);
            rs_ready_alu[s] = b;
            take_mostly_high(b);
            rs_ready_mul[s] = b;
            take_mostly_high(b);
            rob_ready[s] = b;
        end
        take_bits(3, r);
        rob_tail = r[2:0];
        for (int e = 0; e < ROB_DEPTH; e++) begin
            take_bits(1, r);
            rob_entry_valid[e] = r[0];
            take_bits(3, r);
            rob_w_index[e] = {2'b00, r[2:0]};
            take_mostly_high(b);
            rob_w_ready[e] = b;
            take_bits(32, r);
            rob_w_data[e] = r;
        end
    endtask

    initial begin
        int waited;
        lfsr_state = 16'd61075;
        rst        = 1'b1;
        drive_idle();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int cycle = 0; cycle < 3000; cycle++) begin
            @(negedge clk);
            drive_random();
        end
        // Keep going until every behavior has been reached, bounded
        waited = 0;
        while (!(&covered) && waited < 2000) begin
            @(negedge clk);
            drive_random();
            waited++;
        end
        @(negedge clk);
        if (!(&covered)) begin
            $display("Stimulus never reached every checked behavior, coverage bits %b", covered);
            abort_run();
        end else if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// ==== hdl/rvv_dispatch.sv ====
// Two-wide vector dispatch top level, from the uop queue to the ALU/MUL stations and the ROB
module rvv_dispatch
    import dispatch_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,
    // Uop queue
    input  logic      [NUM_DP_UOP-1:0]        uop_valid,
    input  uop_t      [NUM_DP_UOP-1:0]        uop,
    output logic      [NUM_DP_UOP-1:0]        uop_ready,
    // Reservation stations
    output logic      [NUM_DP_UOP-1:0]        rs_valid_alu,
    input  logic      [NUM_DP_UOP-1:0]        rs_ready_alu,
    output logic      [NUM_DP_UOP-1:0]        rs_valid_mul,
    input  logic      [NUM_DP_UOP-1:0]        rs_ready_mul,
    output rs_uop_t   [NUM_DP_UOP-1:0]        rs_uop,
    // ROB push
    output logic      [NUM_DP_UOP-1:0]        rob_valid,
    input  logic      [NUM_DP_UOP-1:0]        rob_ready,
    output rob_push_t [NUM_DP_UOP-1:0]        rob_push,
    input  rob_idx_t                          rob_tail,
    // ROB entries, for RAW check and bypass
    input  logic      [ROB_DEPTH-1:0]         rob_entry_valid,
    input  vreg_idx_t [ROB_DEPTH-1:0]         rob_w_index,
    input  logic      [ROB_DEPTH-1:0]         rob_w_ready,
    input  vdata_t    [ROB_DEPTH-1:0]         rob_w_data,
    // VRF reads, data back in the same cycle
    output vreg_idx_t [NUM_VRF_PORT-1:0]      vrf_rd_index,
    input  vdata_t    [NUM_VRF_PORT-1:0]      vrf_rd_data
);

    port_map_t    [NUM_DP_UOP-1:0] port_map;
    operand_set_t [NUM_DP_UOP-1:0] operands;
    logic         [NUM_DP_UOP-1:0] raw_stall;
    logic                          struct_hazard;

    rob_view_if rob_view ();

    assign rob_view.entry_valid = rob_entry_valid;
    assign rob_view.w_index     = rob_w_index;
    assign rob_view.w_ready     = rob_w_ready;
    assign rob_view.w_data      = rob_w_data;
    assign rob_view.tail        = rob_tail;

    dispatch_vrf_port_alloc u_port_alloc (
        .uops          (uop),
        .uop_valid     (uop_valid),
        .vrf_rd_index  (vrf_rd_index),
        .port_map      (port_map),
        .struct_hazard (struct_hazard)
    );

    for (genvar s = 0; s < NUM_DP_UOP; s++) begin : g_resolve
        dispatch_operand_resolve u_resolve (
            .clk         (clk),
            .rst         (rst),
            .uop         (uop[s]),
            .port_map    (port_map[s]),
            .vrf_rd_data (vrf_rd_data),
            .rob         (rob_view),
            .operands    (operands[s]),
            .raw_stall   (raw_stall[s])
        );
    end

    dispatch_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .uops          (uop),
        .uop_valid     (uop_valid),
        .raw_stall     (raw_stall),
        .struct_hazard (struct_hazard),
        .rs_ready_alu  (rs_ready_alu),
        .rs_ready_mul  (rs_ready_mul),
        .rob_ready     (rob_ready),
        .uop_ready     (uop_ready),
        .rs_valid_alu  (rs_valid_alu),
        .rs_valid_mul  (rs_valid_mul),
        .rob_valid     (rob_valid)
    );

    // Station and ROB payloads, slot s lands at ROB tail + s
    for (genvar s = 0; s < NUM_DP_UOP; s++) begin : g_payload
        assign rs_uop[s].rob_idx        = rob_tail + rob_idx_t'(s);
        assign rs_uop[s].funct6         = uop[s].funct6;
        assign rs_uop[s].vs1_data       = operands[s].vs1;
        assign rs_uop[s].vs1_data_valid = uop[s].vs1_valid;
        assign rs_uop[s].vs2_data       = operands[s].vs2;
        assign rs_uop[s].vs2_data_valid = uop[s].vs2_valid;
        assign rs_uop[s].vs3_data       = operands[s].vs3;
        assign rs_uop[s].vs3_data_valid = uop[s].vs3_valid;
        assign rs_uop[s].rs1_data       = uop[s].rs1_data;

        assign rob_push[s].vd_index     = uop[s].vd_index;
        assign rob_push[s].vd_valid     = uop[s].vd_valid;
    end

endmodule

// ==== hdl/dispatch_ctrl.sv ====
// In-order issue decision for the two dispatch slots and the valid/ready handshakes
module dispatch_ctrl
    import dispatch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  uop_t [NUM_DP_UOP-1:0]  uops,
    input  logic [NUM_DP_UOP-1:0]  uop_valid,
    input  logic [NUM_DP_UOP-1:0]  raw_stall,
    input  logic                   struct_hazard,
    input  logic [NUM_DP_UOP-1:0]  rs_ready_alu,
    input  logic [NUM_DP_UOP-1:0]  rs_ready_mul,
    input  logic [NUM_DP_UOP-1:0]  rob_ready,
    output logic [NUM_DP_UOP-1:0]  uop_ready,
    output logic [NUM_DP_UOP-1:0]  rs_valid_alu,
    output logic [NUM_DP_UOP-1:0]  rs_valid_mul,
    output logic [NUM_DP_UOP-1:0]  rob_valid
);

    logic [NUM_DP_UOP-1:0] to_mul;
    logic [NUM_DP_UOP-1:0] slot_ok;
    logic [NUM_DP_UOP-1:0] can_issue;
    logic                  pair_raw;

    // Per-slot readiness, ignoring the other slot
    always_comb begin
        for (int s = 0; s < NUM_DP_UOP; s++) begin
            to_mul[s]  = (uops[s].exe_unit == EXE_MUL);
            slot_ok[s] = uop_valid[s] & ~raw_stall[s] & rob_ready[s]
                       & (to_mul[s] ? rs_ready_mul[s] : rs_ready_alu[s]);
        end
    end

    // uop1 reads a register that uop0 writes
    assign pair_raw = uops[0].vd_valid
                    & ((uops[1].vs1_valid & (uops[1].vs1_index == uops[0].vd_index))
                     | (uops[1].vs2_valid & (uops[1].vs2_index == uops[0].vd_index))
                     | (uops[1].vs3_valid & (uops[1].vd_index  == uops[0].vd_index)));

    assign can_issue[0] = slot_ok[0];
    assign can_issue[1] = can_issue[0] & slot_ok[1] & ~struct_hazard & ~pair_raw;

    assign uop_ready    = can_issue;
    assign rob_valid    = can_issue;
    assign rs_valid_alu = can_issue & ~to_mul;
    assign rs_valid_mul = can_issue & to_mul;

    a_in_order: assert property (
        @(posedge clk) disable iff (rst)
        uop_ready[1] |-> uop_ready[0]
    ) else $error("slot 1 issued without slot 0");

    a_one_station: assert property (
        @(posedge clk) disable iff (rst)
        (rs_valid_alu & rs_valid_mul) == '0
    ) else $error("ALU and MUL valid both high for one slot");

endmodule

// ==== hdl/dispatch_operand_resolve.sv ====
// Per-uop RAW check against the ROB, picking ROB bypass data or VRF data for each source
module dispatch_operand_resolve
    import dispatch_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  uop_t                          uop,
    input  port_map_t                     port_map,
    input  vdata_t    [NUM_VRF_PORT-1:0]  vrf_rd_data,
    rob_view_if.resolve                   rob,
    output operand_set_t                  operands,
    output logic                          raw_stall
);

    logic      [NUM_SRC-1:0] src_valid;
    vreg_idx_t [NUM_SRC-1:0] src_index;
    vrf_port_t [NUM_SRC-1:0] src_port;

    // Youngest matching writer per source
    logic      [NUM_SRC-1:0] src_hit;
    rob_idx_t  [NUM_SRC-1:0] src_entry;
    vdata_t    [NUM_SRC-1:0] src_data;

    // Entry just behind the tail
    rob_idx_t                youngest;

    // Element 0 is vs1, element 2 is vs3
    assign src_valid = {uop.vs3_valid, uop.vs2_valid, uop.vs1_valid};
    assign src_index = {uop.vd_index, uop.vs2_index, uop.vs1_index};
    assign src_port  = {port_map.vs3_port, port_map.vs2_port, port_map.vs1_port};

    assign youngest  = rob.tail - rob_idx_t'(1);

    always_comb begin
        rob_idx_t e;
        for (int s = 0; s < NUM_SRC; s++) begin
            src_hit[s]   = 1'b0;
            src_entry[s] = '0;
            // Walk from the oldest entry so a younger match overrides it
            for (int d = ROB_DEPTH - 1; d >= 0; d--) begin
                e = rob.tail - rob_idx_t'(d + 1);
                if (src_valid[s] && rob.entry_valid[e] && rob.w_index[e] == src_index[s]) begin
                    src_hit[s]   = 1'b1;
                    src_entry[s] = e;
                end
            end
        end
    end

    always_comb begin
        raw_stall = 1'b0;
        for (int s = 0; s < NUM_SRC; s++) begin
            if (!src_valid[s]) begin
                src_data[s] = '0;
            end else if (src_hit[s]) begin
                src_data[s] = rob.w_data[src_entry[s]];
                // Writer still in flight
                if (!rob.w_ready[src_entry[s]]) begin
                    raw_stall = 1'b1;
                end
            end else begin
                src_data[s] = vrf_rd_data[src_port[s]];
            end
        end
    end

    assign operands.vs1 = src_data[0];
    assign operands.vs2 = src_data[1];
    assign operands.vs3 = src_data[2];

    // A pending write in the youngest entry wins over any older ready copy
    for (genvar s = 0; s < NUM_SRC; s++) begin : g_chk
        a_no_unready_bypass: assert property (
            @(posedge clk) disable iff (rst)
            (src_valid[s] && rob.entry_valid[youngest] && !rob.w_ready[youngest]
             && rob.w_index[youngest] == src_index[s]) |-> raw_stall
        ) else $error("operand taken from a ROB entry that is not ready");
    end

endmodule

// ==== hdl/dispatch_vrf_port_alloc.sv ====
// Hands out the four VRF read ports in operand order and flags the read-port structure hazard
module dispatch_vrf_port_alloc
    import dispatch_pkg::*;
(
    input  uop_t      [NUM_DP_UOP-1:0]   uops,
    input  logic      [NUM_DP_UOP-1:0]   uop_valid,
    output vreg_idx_t [NUM_VRF_PORT-1:0] vrf_rd_index,
    output port_map_t [NUM_DP_UOP-1:0]   port_map,
    output logic                         struct_hazard
);

    localparam int NUM_OPS = NUM_DP_UOP * NUM_SRC;

    logic      [NUM_OPS-1:0] op_valid;
    vreg_idx_t [NUM_OPS-1:0] op_index;
    vrf_port_t [NUM_OPS-1:0] op_port;
    logic      [NUM_OPS-1:0] op_fits;

    // Flatten to uop0 vs1, vs2, vs3 then uop1 vs1, vs2, vs3
    always_comb begin
        for (int s = 0; s < NUM_DP_UOP; s++) begin
            op_valid[s*NUM_SRC]     = uop_valid[s] & uops[s].vs1_valid;
            op_index[s*NUM_SRC]     = uops[s].vs1_index;
            op_valid[s*NUM_SRC + 1] = uop_valid[s] & uops[s].vs2_valid;
            op_index[s*NUM_SRC + 1] = uops[s].vs2_index;
            op_valid[s*NUM_SRC + 2] = uop_valid[s] & uops[s].vs3_valid;
            op_index[s*NUM_SRC + 2] = uops[s].vd_index;
        end
    end

    always_comb begin
        int   used;
        logic clash;
        used          = 0;
        clash         = 1'b0;
        vrf_rd_index  = '0;   // idle ports read v0
        struct_hazard = 1'b0;
        for (int k = 0; k < NUM_OPS; k++) begin
            op_port[k] = vrf_port_t'(used);
            op_fits[k] = (used < NUM_VRF_PORT);
            if (op_valid[k]) begin
                if (op_fits[k]) begin
                    vrf_rd_index[op_port[k]] = op_index[k];
                end else begin
                    // uop0 never exceeds three ports, so only uop1 lands here
                    struct_hazard = 1'b1;
                end
                used++;
            end
        end
        // Port sharing between valid operands
        for (int i = 0; i < NUM_OPS; i++) begin
            for (int j = i + 1; j < NUM_OPS; j++) begin
                if (op_valid[i] && op_valid[j] && op_port[i] == op_port[j]) begin
                    clash = 1'b1;
                end
            end
        end
        a_no_shared_port: assert final (struct_hazard || !clash)
            else $error("two valid operands share a VRF read port");
    end

    always_comb begin
        for (int s = 0; s < NUM_DP_UOP; s++) begin
            port_map[s].vs1_port = op_port[s*NUM_SRC];
            port_map[s].vs2_port = op_port[s*NUM_SRC + 1];
            port_map[s].vs3_port = op_port[s*NUM_SRC + 2];
        end
    end

endmodule

// ==== hdl/rob_view_if.sv ====
// ROB entry view bundle, driven by the dispatch top level and read by each operand resolver
interface rob_view_if
    import dispatch_pkg::*;
();

    logic      [ROB_DEPTH-1:0] entry_valid;
    vreg_idx_t [ROB_DEPTH-1:0] w_index;
    logic      [ROB_DEPTH-1:0] w_ready;
    vdata_t    [ROB_DEPTH-1:0] w_data;
    // Next free slot, so tail-1 holds the youngest entry
    rob_idx_t                  tail;

    modport source (
        output entry_valid, w_index, w_ready, w_data, tail
    );

    modport resolve (
        input entry_valid, w_index, w_ready, w_data, tail
    );

endinterface

// ==== hdl/dispatch_pkg.sv ====
// Constants and payload types shared by every block of the two-wide vector dispatch stage
package dispatch_pkg;

    localparam int NUM_DP_UOP   = 2;
    localparam int NUM_VRF_PORT = 4;
    localparam int ROB_DEPTH    = 8;
    localparam int ROB_IDX_W    = 3;
    localparam int VREG_IDX_W   = 5;
    localparam int VLEN         = 32;
    // Source operands per uop, in the order vs1, vs2, vs3
    localparam int NUM_SRC      = 3;

    typedef logic [VREG_IDX_W-1:0]           vreg_idx_t;
    typedef logic [VLEN-1:0]                 vdata_t;
    typedef logic [ROB_IDX_W-1:0]            rob_idx_t;
    typedef logic [$clog2(NUM_VRF_PORT)-1:0] vrf_port_t;

    typedef enum logic {
        EXE_ALU = 1'b0,
        EXE_MUL = 1'b1
    } exe_unit_e;

    // Uop as it leaves the uop queue
    typedef struct packed {
        vreg_idx_t   vs1_index;
        logic        vs1_valid;
        vreg_idx_t   vs2_index;
        logic        vs2_valid;
        vreg_idx_t   vd_index;
        logic        vs3_valid;   // vd is also read as a source
        logic        vd_valid;    // vd is written
        exe_unit_e   exe_unit;
        logic [5:0]  funct6;
        logic [7:0]  rs1_data;
    } uop_t;

    // VRF read port given to each source of one uop
    typedef struct packed {
        vrf_port_t vs1_port;
        vrf_port_t vs2_port;
        vrf_port_t vs3_port;
    } port_map_t;

    typedef struct packed {
        vdata_t vs1;
        vdata_t vs2;
        vdata_t vs3;
    } operand_set_t;

    // Payload shared by the ALU and MUL reservation stations
    typedef struct packed {
        rob_idx_t    rob_idx;
        logic [5:0]  funct6;
        vdata_t      vs1_data;
        logic        vs1_data_valid;
        vdata_t      vs2_data;
        logic        vs2_data_valid;
        vdata_t      vs3_data;
        logic        vs3_data_valid;
        logic [7:0]  rs1_data;
    } rs_uop_t;

    typedef struct packed {
        vreg_idx_t vd_index;
        logic      vd_valid;
    } rob_push_t;

endpackage
